// ==== testbench/dcache_golden.txt ====
// golden accesses of the data cache testbench, one access per line
// columns: op (0 read, 1 write, f end) word_addr wdata exp_rdata mem_reads mem_writes
// untouched memory words hold word address xor a5000000
// clean miss, then a hit in the same line
0 00000010 00000000 a5000010 1 0
0 00000011 00000000 a5000011 0 0
// write hit, the written word, a neighbour untouched
1 00000012 cafe0012 00000000 0 0
0 00000012 00000000 cafe0012 0 0
0 00000013 00000000 a5000013 0 0
// three tags in set 0 push the dirty line out and bring it back
0 00000020 00000000 a5000020 1 0
0 00000030 00000000 a5000030 1 1
0 00000012 00000000 cafe0012 1 0
0 00000011 00000000 a5000011 0 0
// set 1: A, B, touch A, C evicts B, A still hits
0 00000014 00000000 a5000014 1 0
0 00000025 00000000 a5000025 1 0
0 00000016 00000000 a5000016 0 0
0 00000037 00000000 a5000037 1 0
0 00000015 00000000 a5000015 0 0
0 00000024 00000000 a5000024 1 0
// two fresh tags in every set
0 00000040 00000000 a5000040 1 0
0 00000045 00000000 a5000045 1 0
0 0000004a 00000000 a500004a 1 0
0 0000004f 00000000 a500004f 1 0
0 00000052 00000000 a5000052 1 0
0 00000057 00000000 a5000057 1 0
0 00000058 00000000 a5000058 1 0
0 0000005d 00000000 a500005d 1 0
// all eight lines still present
0 00000041 00000000 a5000041 0 0
0 00000046 00000000 a5000046 0 0
0 0000004b 00000000 a500004b 0 0
0 0000004c 00000000 a500004c 0 0
0 00000053 00000000 a5000053 0 0
0 00000054 00000000 a5000054 0 0
0 00000059 00000000 a5000059 0 0
0 0000005e 00000000 a500005e 0 0
f 00000000 00000000 00000000 0 0

// ==== dcache.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_lookup.sv
design/dcache_ctrl.sv
design/dcache_store.sv
design/dcache_top.sv
testbench/tb_slow_mem.sv
testbench/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "failure reported in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "no verdict found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_dcache.sv ====
// testbench of the data cache, replays the golden access file against dcache_top
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 8;
	localparam int    MEM_LATENCY  = 3;
	localparam word_t MEM_INIT_XOR = 32'hA500_0000;
	localparam int    MAX_ACCESSES = 64;
	localparam int    FIELDS       = 6; // op, addr, wdata, rdata, reads, writes
	localparam string GOLDEN_FILE  = "testbench/dcache_golden.txt";

	logic       clk;
	logic       proc_reset;
	logic       proc_read;
	logic       proc_write;
	proc_addr_t proc_addr;
	word_t      proc_wdata;
	logic       proc_stall;
	word_t      proc_rdata;
	logic       mem_read;
	logic       mem_write;
	mem_addr_t  mem_addr;
	line_t      mem_wdata;
	line_t      mem_rdata;
	logic       mem_ready;
	int         read_count;
	int         write_count;

	logic [31:0] golden [MAX_ACCESSES*FIELDS];
	int          n_accesses;
	int          cycle_limit = 0;
	int          cycle_cnt = 0;

	dcache_top uut (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata),
		.proc_stall(proc_stall), .proc_rdata(proc_rdata),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	tb_slow_mem #(.MEM_LATENCY(MEM_LATENCY), .MEM_INIT_XOR(MEM_INIT_XOR)) u_mem (
		.clk(clk), .proc_reset(proc_reset),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
		.read_count(read_count), .write_count(write_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ends a run that never reaches its verdict
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: no verdict after %0d cycles", cycle_cnt);
			$display("Simulation FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	// --------------------------------------------------
	// checks, first error stops the run
	// --------------------------------------------------
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0d ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("MISMATCH at %0d ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	function automatic int count_accesses();
		int n;
		n = -1;
		for (int i = 0; i < MAX_ACCESSES; i++) begin
			if (n < 0 && golden[i*FIELDS] == 32'hF) n = i; // end record
		end
		return n;
	endfunction

	// one access, held until the stall drops
	task automatic run_access(input int idx);
		logic [31:0] op;
		word_t       expected;
		int          exp_reads;
		int          exp_writes;
		int          reads0;
		int          writes0;
		op         = golden[idx*FIELDS];
		expected   = golden[idx*FIELDS+3];
		exp_reads  = int'(golden[idx*FIELDS+4]);
		exp_writes = int'(golden[idx*FIELDS+5]);
		if (op != 32'h0 && op != 32'h1)
			abort_run($sformatf("golden record %0d has an unknown operation %h", idx, op));
		reads0  = read_count;
		writes0 = write_count;
		@(posedge clk);
		proc_read  <= (op == 32'h0);
		proc_write <= (op == 32'h1);
		proc_addr  <= proc_addr_t'(golden[idx*FIELDS+1]);
		proc_wdata <= golden[idx*FIELDS+2];
		@(negedge clk);
		check_bit("proc_stall", proc_stall, (exp_reads + exp_writes) != 0); // miss stalls at once
		while (proc_stall) @(negedge clk);
		if (op == 32'h0) check_word("proc_rdata", proc_rdata, expected);
		check_count("mem_read requests", read_count - reads0, exp_reads);
		check_count("mem_write requests", write_count - writes0, exp_writes);
		@(posedge clk);
		proc_read  <= 1'b0; // write is stored at this edge
		proc_write <= 1'b0;
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		proc_reset <= 1'b1;
		proc_read  <= 1'b0;
		proc_write <= 1'b0;
		proc_addr  <= '0;
		proc_wdata <= '0;
		$readmemh(GOLDEN_FILE, golden);
		n_accesses = count_accesses();
		if (n_accesses < 1) abort_run("golden file has no accesses or no end record");
		cycle_limit = n_accesses * (2 * MEM_LATENCY + 8) + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		proc_reset <= 1'b0;
		@(negedge clk);
		check_bit("proc_stall", proc_stall, 1'b0); // idle after reset
		check_bit("mem_read", mem_read, 1'b0);
		check_bit("mem_write", mem_write, 1'b0);

		for (int i = 0; i < n_accesses; i++) run_access(i);

		@(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_slow_mem.sv ====
// slow line memory model for the data cache testbench, answers after a fixed latency
`timescale 1ns/1ps
`default_nettype none

module tb_slow_mem import dcache_pkg::*; #(
	parameter int    MEM_LATENCY  = 3,
	parameter word_t MEM_INIT_XOR = 32'hA500_0000
) (
	input  logic      clk,
	input  logic      proc_reset,
	input  logic      mem_read,
	input  logic      mem_write,
	input  mem_addr_t mem_addr,
	input  line_t     mem_wdata,
	output line_t     mem_rdata,
	output logic      mem_ready,
	output int        read_count,  // fills served
	output int        write_count  // write-backs taken
);

	line_t lines [mem_addr_t]; // only lines written back are stored
	int    wait_cnt;

	// untouched lines hold word address xor a constant in every word
	function automatic line_t init_line(input mem_addr_t line_addr);
		line_t line;
		word_t word_addr;
		for (int w = 0; w < 4; w++) begin
			word_addr = word_t'({line_addr, 2'(w)});
			line[w*32 +: 32] = word_addr ^ MEM_INIT_XOR;
		end
		return line;
	endfunction

	// --------------------------------------------------
	// request handling, one request at a time
	// --------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready   <= 1'b0;
			mem_rdata   <= '0;
			wait_cnt    <= 0;
			read_count  <= 0;
			write_count <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0; // request drops after the ready cycle
			wait_cnt  <= 0;
		end else if (mem_read || mem_write) begin
			if (wait_cnt == MEM_LATENCY - 1) begin
				mem_ready <= 1'b1;
				if (mem_write) begin
					lines[mem_addr] = mem_wdata;
					write_count <= write_count + 1;
				end else begin
					mem_rdata  <= lines.exists(mem_addr) ? lines[mem_addr]
					                                     : init_line(mem_addr);
					read_count <= read_count + 1;
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// top level of the data cache, joins lookup, controller and store to both ports
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
	input  logic       clk,
	input  logic       proc_reset,
	// processor side
	input  logic       proc_read,
	input  logic       proc_write,
	input  proc_addr_t proc_addr,
	input  word_t      proc_wdata,
	output logic       proc_stall,
	output word_t      proc_rdata,
	// slow memory side
	output logic       mem_read,
	output logic       mem_write,
	output mem_addr_t  mem_addr,
	output line_t      mem_wdata,
	input  line_t      mem_rdata,
	input  logic       mem_ready
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	set_idx_t  set_idx;
	word_sel_t word_sel;
	tag_t      req_tag;
	tag_t      way0_tag;
	tag_t      way1_tag;
	logic      way0_valid;
	logic      way1_valid;
	logic      way0_dirty;
	logic      way1_dirty;
	way_t      lru_way;
	logic      hit;
	way_t      hit_way;
	way_t      victim_way;
	logic      victim_dirty;
	mem_addr_t fill_addr;
	mem_addr_t victim_addr;
	logic      write_word_en;
	logic      touch_en;
	logic      refill_en;
	logic      writeback_done;

	dcache_lookup u_lookup (
		.proc_addr    (proc_addr),
		.way0_tag     (way0_tag),
		.way1_tag     (way1_tag),
		.way0_valid   (way0_valid),
		.way1_valid   (way1_valid),
		.way0_dirty   (way0_dirty),
		.way1_dirty   (way1_dirty),
		.lru_way      (lru_way),
		.set_idx      (set_idx),
		.word_sel     (word_sel),
		.req_tag      (req_tag),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.fill_addr    (fill_addr),
		.victim_addr  (victim_addr)
	);

	dcache_ctrl u_ctrl (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.proc_read      (proc_read),
		.proc_write     (proc_write),
		.hit            (hit),
		.victim_dirty   (victim_dirty),
		.fill_addr      (fill_addr),
		.victim_addr    (victim_addr),
		.mem_ready      (mem_ready),
		.proc_stall     (proc_stall),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.write_word_en  (write_word_en),
		.touch_en       (touch_en),
		.refill_en      (refill_en),
		.writeback_done (writeback_done)
	);

	dcache_store u_store (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.set_idx        (set_idx),
		.word_sel       (word_sel),
		.req_tag        (req_tag),
		.hit_way        (hit_way),
		.victim_way     (victim_way),
		.write_word_en  (write_word_en),
		.touch_en       (touch_en),
		.refill_en      (refill_en),
		.writeback_done (writeback_done),
		.proc_wdata     (proc_wdata),
		.mem_rdata      (mem_rdata),
		.way0_tag       (way0_tag),
		.way1_tag       (way1_tag),
		.way0_valid     (way0_valid),
		.way1_valid     (way1_valid),
		.way0_dirty     (way0_dirty),
		.way1_dirty     (way1_dirty),
		.lru_way        (lru_way),
		.proc_rdata     (proc_rdata),
		.victim_line    (mem_wdata) // victim line is the write-back data
	);

endmodule

`default_nettype wire

// ==== design/dcache_store.sv ====
// tag, state and data arrays of the two-way data cache with their update rules
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_store import dcache_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	// decoded request
	input  set_idx_t  set_idx,
	input  word_sel_t word_sel,
	input  tag_t      req_tag,
	input  way_t      hit_way,
	input  way_t      victim_way,
	// update enables from the controller
	input  logic      write_word_en,
	input  logic      touch_en,
	input  logic      refill_en,
	input  logic      writeback_done,
	// write data
	input  word_t     proc_wdata,
	input  line_t     mem_rdata,
	// indexed set, back to lookup
	output tag_t      way0_tag,
	output tag_t      way1_tag,
	output logic      way0_valid,
	output logic      way1_valid,
	output logic      way0_dirty,
	output logic      way1_dirty,
	output way_t      lru_way,
	// read side
	output word_t     proc_rdata,
	output line_t     victim_line
);

	// --------------------------------------------------
	// arrays, first index is the way
	// --------------------------------------------------
	line_t data_mem  [2][`DCACHE_SETS];
	tag_t  tag_mem   [2][`DCACHE_SETS];
	logic  valid_q   [2][`DCACHE_SETS];
	logic  dirty_q   [2][`DCACHE_SETS];
	way_t  lru_q     [`DCACHE_SETS]; // least recently used way per set
	line_t hit_line;

	// valid, dirty and lru bits
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				valid_q[0][s] <= 1'b0;
				valid_q[1][s] <= 1'b0;
				dirty_q[0][s] <= 1'b0;
				dirty_q[1][s] <= 1'b0;
				lru_q[s]      <= 1'b0;
			end
		end else begin
			if (write_word_en) begin
				dirty_q[hit_way][set_idx] <= 1'b1;
			end
			if (touch_en) begin
				lru_q[set_idx] <= ~hit_way; // other way is now older
			end
			if (writeback_done) begin
				dirty_q[victim_way][set_idx] <= 1'b0;
			end
			if (refill_en) begin
				valid_q[victim_way][set_idx] <= 1'b1;
				dirty_q[victim_way][set_idx] <= 1'b0;
				lru_q[set_idx]               <= ~victim_way;
			end
		end
	end

	// data and tags
	always_ff @(posedge clk) begin
		if (write_word_en) begin
			data_mem[hit_way][set_idx][word_sel * `DCACHE_WORD_W +: `DCACHE_WORD_W]
				<= proc_wdata;
		end
		if (refill_en) begin
			data_mem[victim_way][set_idx] <= mem_rdata;
			tag_mem[victim_way][set_idx]  <= req_tag;
		end
	end

	// --------------------------------------------------
	// read side, combinational
	// --------------------------------------------------
	assign way0_tag   = tag_mem[0][set_idx];
	assign way1_tag   = tag_mem[1][set_idx];
	assign way0_valid = valid_q[0][set_idx];
	assign way1_valid = valid_q[1][set_idx];
	assign way0_dirty = dirty_q[0][set_idx];
	assign way1_dirty = dirty_q[1][set_idx];
	assign lru_way    = lru_q[set_idx];

	assign hit_line    = data_mem[hit_way][set_idx];
	assign proc_rdata  = hit_line[word_sel * `DCACHE_WORD_W +: `DCACHE_WORD_W];
	assign victim_line = data_mem[victim_way][set_idx]; // write-back payload

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
// miss handling FSM of the data cache, drives the stall and the memory requests
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
	input  logic      clk,
	input  logic      proc_reset,
	// processor request
	input  logic      proc_read,
	input  logic      proc_write,
	// from lookup
	input  logic      hit,
	input  logic      victim_dirty,
	input  mem_addr_t fill_addr,
	input  mem_addr_t victim_addr,
	// memory side
	input  logic      mem_ready,
	output logic      proc_stall,
	output logic      mem_read,
	output logic      mem_write,
	output mem_addr_t mem_addr,
	// update enables into the store
	output logic      write_word_en,
	output logic      touch_en,
	output logic      refill_en,
	output logic      writeback_done
);

	cache_state_t state;
	cache_state_t state_nxt;
	logic         req;

	assign req = proc_read || proc_write;

	// --------------------------------------------------
	// state register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= compare_tag; // no idle state, first request is served
		end else begin
			state <= state_nxt;
		end
	end

	// --------------------------------------------------
	// next state and outputs
	// --------------------------------------------------
	always_comb begin
		state_nxt      = state;
		proc_stall     = 1'b0;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		mem_addr       = fill_addr;
		write_word_en  = 1'b0;
		touch_en       = 1'b0;
		refill_en      = 1'b0;
		writeback_done = 1'b0;

		case (state)
			compare_tag: begin
				if (req && hit) begin
					touch_en      = 1'b1;
					write_word_en = proc_write;
				end else if (req) begin
					proc_stall = 1'b1;
					// dirty victim must go out before the fill
					state_nxt  = victim_dirty ? write_back : allocate;
				end
			end

			write_back: begin
				proc_stall = 1'b1;
				mem_write  = 1'b1; // held through the ready cycle
				mem_addr   = victim_addr;
				if (mem_ready) begin
					writeback_done = 1'b1;
					state_nxt      = allocate;
				end
			end

			allocate: begin
				proc_stall = 1'b1;
				mem_read   = 1'b1;
				if (mem_ready) begin
					refill_en = 1'b1; // mem_rdata taken at this edge
					state_nxt = compare_tag;
				end
			end

			default: begin
				state_nxt = compare_tag;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/dcache_lookup.sv ====
// address decode and tag compare of the data cache, purely combinational
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_lookup import dcache_pkg::*; (
	input  proc_addr_t proc_addr,
	// indexed set, read back from the store
	input  tag_t       way0_tag,
	input  tag_t       way1_tag,
	input  logic       way0_valid,
	input  logic       way1_valid,
	input  logic       way0_dirty,
	input  logic       way1_dirty,
	input  way_t       lru_way,
	// decoded request
	output set_idx_t   set_idx,
	output word_sel_t  word_sel,
	output tag_t       req_tag,
	// hit and replacement info
	output logic       hit,
	output way_t       hit_way,
	output way_t       victim_way,
	output logic       victim_dirty,
	output mem_addr_t  fill_addr,
	output mem_addr_t  victim_addr
);

	logic match0;
	logic match1;
	tag_t victim_tag;

	// --------------------------------------------------
	// field split: tag | index | word
	// --------------------------------------------------
	assign word_sel = proc_addr[`DCACHE_WORD_SEL_W-1:0];
	assign set_idx  = proc_addr[`DCACHE_WORD_SEL_W +: `DCACHE_INDEX_W];
	assign req_tag  = proc_addr[`DCACHE_PROC_ADDR_W-1 -: `DCACHE_TAG_W];

	// --------------------------------------------------
	// tag compare
	// --------------------------------------------------
	assign match0 = way0_valid && (way0_tag == req_tag);
	assign match1 = way1_valid && (way1_tag == req_tag);

	assign hit     = match0 || match1;
	assign hit_way = match1; // way 0 unless way 1 matched

	// least recently used way is replaced
	assign victim_way   = lru_way;
	assign victim_tag   = victim_way ? way1_tag : way0_tag;
	assign victim_dirty = victim_way ? (way1_valid && way1_dirty)
	                                 : (way0_valid && way0_dirty);

	// line addresses toward slow memory
	assign fill_addr   = {req_tag, set_idx};
	assign victim_addr = {victim_tag, set_idx};

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
// shared types of the data cache, imported by every cache module
`default_nettype none

package dcache_pkg;

`include "dcache_settings.svh"

	// --------------------------------------------------
	// data and address fields
	// --------------------------------------------------
	typedef logic [`DCACHE_WORD_W-1:0]      word_t;
	typedef logic [`DCACHE_LINE_W-1:0]      line_t;
	typedef logic [`DCACHE_TAG_W-1:0]       tag_t;
	typedef logic [`DCACHE_INDEX_W-1:0]     set_idx_t;
	typedef logic [`DCACHE_WORD_SEL_W-1:0]  word_sel_t;
	typedef logic [`DCACHE_PROC_ADDR_W-1:0] proc_addr_t;
	typedef logic [`DCACHE_MEM_ADDR_W-1:0]  mem_addr_t;

	// two ways, so one bit names a way
	typedef logic way_t;

	// --------------------------------------------------
	// controller states
	// --------------------------------------------------
	typedef enum logic [1:0] {
		compare_tag = 2'b00, // lookup, hits finish here
		write_back  = 2'b01, // dirty victim out to memory
		allocate    = 2'b10  // line fill from memory
	} cache_state_t;

endpackage

`default_nettype wire

// ==== design/dcache_settings.svh ====
// data cache geometry, included by the package and by modules that size arrays
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// --------------------------------------------------
// cache organization
// --------------------------------------------------
`define DCACHE_SETS        4    // sets per way
`define DCACHE_INDEX_W     2    // log2 of set count
`define DCACHE_WORD_SEL_W  2    // four words per line

// --------------------------------------------------
// data and address widths
// --------------------------------------------------
`define DCACHE_WORD_W      32
`define DCACHE_LINE_W      128
`define DCACHE_TAG_W       26   // proc addr minus index and word select
`define DCACHE_PROC_ADDR_W 30   // word address
`define DCACHE_MEM_ADDR_W  28   // line address

`endif
